/* alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fu_params.svh"

module alu_unit (
  input  fu_pkg::fu_req_t req_i,
  output fu_pkg::fu_wb_t  wb_o
);

  import fu_pkg::*;

  word_t                    result;
  logic [`FU_SHAMT_BITS-1:0] shamt;

  // only the low bits of src2 count for shifts
  assign shamt = req_i.src2[`FU_SHAMT_BITS-1:0];

  // ==============================
  // operation select
  // ==============================
  always_comb begin
    case (req_i.alu_op)
      ALU_ADD:  result = req_i.src1 + req_i.src2;
      ALU_SUB:  result = req_i.src1 - req_i.src2;
      ALU_AND:  result = req_i.src1 & req_i.src2;
      ALU_OR:   result = req_i.src1 | req_i.src2;
      ALU_XOR:  result = req_i.src1 ^ req_i.src2;
      // compares give 0 or 1
      ALU_SLT:  result = word_t'($signed(req_i.src1) < $signed(req_i.src2));
      ALU_SLTU: result = word_t'(req_i.src1 < req_i.src2);
      ALU_SLL:  result = req_i.src1 << shamt;
      ALU_SRL:  result = req_i.src1 >> shamt;
      // arithmetic shift keeps the sign
      ALU_SRA:  result = word_t'($signed(req_i.src1) >>> shamt);
      default:  result = '0;
    endcase
  end

  // result record, tags echoed from the request
  always_comb begin
    wb_o.valid      = req_i.valid;
    wb_o.value      = result;
    wb_o.dest_prf   = req_i.dest_tag;
    wb_o.rob_idx    = req_i.rob_idx;
    // not a control-flow op
    wb_o.taken      = 1'b0;
    wb_o.is_jump    = 1'b0;
    wb_o.link_value = '0;
  end

  // issue must never hand us an undefined op
  always_comb begin
    assert (!req_i.valid || (req_i.alu_op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
                                                  ALU_XOR, ALU_SLT, ALU_SLTU, ALU_SLL,
                                                  ALU_SRL, ALU_SRA}))
      else $error("alu_unit: illegal alu_op %0d", req_i.alu_op);
  end

endmodule

`default_nettype wire

/* branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
  input  fu_pkg::fu_req_t req_i,
  output fu_pkg::fu_wb_t  wb_o
);

  import fu_pkg::*;

  fu_req_t add_req;
  fu_wb_t  target_wb;
  logic    take;

  // ==============================
  // target adder
  // ==============================

  // reuse the integer ALU as pc + imm
  always_comb begin
    add_req        = req_i;
    add_req.alu_op = ALU_ADD;
    add_req.src1   = req_i.pc;
    add_req.src2   = req_i.imm;
  end

  alu_unit u_target_alu (
    .req_i (add_req),
    .wb_o  (target_wb)
  );

  // ==============================
  // condition evaluation
  // ==============================
  always_comb begin
    if (req_i.uncond) begin
      // jumps always redirect
      take = 1'b1;
    end else begin
      case (req_i.funct3)
        3'b000:  take = (req_i.src1 == req_i.src2);                   // beq
        3'b001:  take = (req_i.src1 != req_i.src2);                   // bne
        3'b100:  take = ($signed(req_i.src1) <  $signed(req_i.src2)); // blt
        3'b101:  take = ($signed(req_i.src1) >= $signed(req_i.src2)); // bge
        3'b110:  take = (req_i.src1 <  req_i.src2);                   // bltu
        3'b111:  take = (req_i.src1 >= req_i.src2);                   // bgeu
        // 010 and 011 are not branches
        default: take = 1'b0;
      endcase
    end
  end

  // target as value, return address as link
  always_comb begin
    wb_o.valid      = req_i.valid;
    wb_o.value      = target_wb.value;
    wb_o.dest_prf   = req_i.dest_tag;
    wb_o.rob_idx    = req_i.rob_idx;
    wb_o.taken      = take;
    wb_o.is_jump    = req_i.uncond;
    wb_o.link_value = req_i.npc;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
fu_pkg.sv
alu_unit.sv
mul_unit.sv
lsu_agu.sv
branch_unit.sv
fu_cluster.sv
tb_fu_cluster.sv

/* fu_cluster.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fu_params.svh"

module fu_cluster (
  input  logic            clock,
  input  logic            reset,
  // one issue port per unit
  input  fu_pkg::fu_req_t alu_req_i,
  input  fu_pkg::fu_req_t mul_req_i,
  input  fu_pkg::fu_req_t ls_req_i,
  input  fu_pkg::fu_req_t br_req_i,
  // write-back bus, one slot per unit
  output fu_pkg::fu_wb_t  wb_o [fu_pkg::WB_SLOTS],
  // toward the load/store queue
  output fu_pkg::fu_lsq_t lsq_o
);

  import fu_pkg::*;

  // ==============================
  // integer ALU, same cycle
  // ==============================
  alu_unit u_alu (
    .req_i (alu_req_i),
    .wb_o  (wb_o[WB_ALU])
  );

  // ==============================
  // multiplier, fixed latency
  // ==============================
  mul_unit #(
    .STAGES (`FU_MUL_STAGES)
  ) u_mul (
    .clock (clock),
    .reset (reset),
    .req_i (mul_req_i),
    .wb_o  (wb_o[WB_MUL])
  );

  // ==============================
  // load/store address unit
  // ==============================

  // goes to the queue, not onto write-back
  lsu_agu u_agu (
    .req_i (ls_req_i),
    .lsq_o (lsq_o)
  );

  // ==============================
  // branch resolution
  // ==============================
  branch_unit u_br (
    .req_i (br_req_i),
    .wb_o  (wb_o[WB_BR])
  );

endmodule

`default_nettype wire

/* fu_params.svh */
`ifndef FU_PARAMS_SVH
`define FU_PARAMS_SVH

// ==============================
// datapath sizing
// ==============================

// integer data width
`define FU_XLEN        32

// physical register file and reorder buffer
`define FU_PHYS_REGS   128
`define FU_ROB_DEPTH   64

// multiplier latency in cycles
`define FU_MUL_STAGES  3

// raw immediate and shift field widths
`define FU_IMM_BITS    12
`define FU_SHAMT_BITS  5

`endif

/* fu_pkg.sv */
`default_nettype none

`include "fu_params.svh"

package fu_pkg;

  // derived widths
  localparam int XLEN         = `FU_XLEN;
  localparam int PRF_TAG_BITS = $clog2(`FU_PHYS_REGS);
  localparam int ROB_IDX_BITS = $clog2(`FU_ROB_DEPTH);

  typedef logic [XLEN-1:0]         word_t;
  typedef logic [PRF_TAG_BITS-1:0] prf_tag_t;
  typedef logic [ROB_IDX_BITS-1:0] rob_idx_t;

  // ==============================
  // operation encodings
  // ==============================

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLT  = 4'd5,
    ALU_SLTU = 4'd6,
    ALU_SLL  = 4'd7,
    ALU_SRL  = 4'd8,
    ALU_SRA  = 4'd9
  } alu_op_t;

  // same values as funct3 of the M extension
  typedef enum logic [2:0] {
    MF_MUL    = 3'd0,
    MF_MULH   = 3'd1,
    MF_MULHSU = 3'd2,
    MF_MULHU  = 3'd3
  } mul_func_t;

  // ==============================
  // issue, write-back, queue records
  // ==============================

  // imm is the decoded immediate, already a full word
  typedef struct packed {
    logic       valid;
    alu_op_t    alu_op;
    logic [2:0] funct3;
    word_t      src1;
    word_t      src2;
    word_t      imm;
    word_t      pc;
    word_t      npc;
    prf_tag_t   dest_tag;
    rob_idx_t   rob_idx;
    logic       is_load;
    logic       is_store;
    logic       uncond;
  } fu_req_t;

  typedef struct packed {
    logic     valid;
    word_t    value;
    prf_tag_t dest_prf;
    rob_idx_t rob_idx;
    logic     taken;
    logic     is_jump;
    word_t    link_value;
  } fu_wb_t;

  typedef struct packed {
    logic       valid;
    logic       is_store;
    rob_idx_t   rob_idx;
    prf_tag_t   dest_prf;
    word_t      addr;
    word_t      store_data;
    // access size and sign extension
    logic [2:0] funct3;
  } fu_lsq_t;

  // write-back slot map
  localparam int WB_SLOTS = 3;
  localparam int WB_ALU   = 0;
  localparam int WB_MUL   = 1;
  localparam int WB_BR    = 2;

endpackage

`default_nettype wire

/* lsu_agu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fu_params.svh"

module lsu_agu (
  input  fu_pkg::fu_req_t req_i,
  output fu_pkg::fu_lsq_t lsq_o
);

  import fu_pkg::*;

  word_t imm_sext;
  word_t addr;

  // ==============================
  // address generation
  // ==============================

  // sign-extend the raw I/S immediate field
  assign imm_sext = {{(XLEN-`FU_IMM_BITS){req_i.imm[`FU_IMM_BITS-1]}},
                     req_i.imm[`FU_IMM_BITS-1:0]};
  assign addr     = req_i.src1 + imm_sext;

  // queue record
  always_comb begin
    lsq_o.valid    = req_i.valid && (req_i.is_load || req_i.is_store);
    lsq_o.is_store = req_i.is_store;
    lsq_o.rob_idx  = req_i.rob_idx;
    lsq_o.addr     = addr;
    // neither flag means no access, fields idle at zero
    lsq_o.dest_prf   = '0;
    lsq_o.store_data = '0;
    lsq_o.funct3     = '0;
    if (req_i.is_load) begin
      // loads need a destination and width/sign
      lsq_o.dest_prf = req_i.dest_tag;
      lsq_o.funct3   = req_i.funct3;
    end else if (req_i.is_store) begin
      // stores carry rs2 as data, no destination
      lsq_o.store_data = req_i.src2;
    end
  end

  // decode marks an op as load or store, not both
  always_comb begin
    assert (!(req_i.is_load && req_i.is_store))
      else $error("lsu_agu: request flagged as both load and store");
  end

endmodule

`default_nettype wire

/* mul_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fu_params.svh"

module mul_unit #(
  parameter int STAGES = `FU_MUL_STAGES
) (
  input  logic            clock,
  input  logic            reset,
  input  fu_pkg::fu_req_t req_i,
  output fu_pkg::fu_wb_t  wb_o
);

  import fu_pkg::*;

  // payload carried down the pipe with its tags
  typedef struct packed {
    logic              take_high;
    logic [2*XLEN-1:0] product;
    prf_tag_t          dest_tag;
    rob_idx_t          rob_idx;
  } mul_data_t;

  mul_func_t          func;
  logic               sign_a;
  logic               sign_b;
  logic signed [XLEN:0]     a_ext;
  logic signed [XLEN:0]     b_ext;
  logic signed [2*XLEN+1:0] product_full;
  mul_data_t          data_in;

  logic [STAGES-1:0]  valid_q;
  mul_data_t          data_q [STAGES];

  // ==============================
  // operand extension and product
  // ==============================
  assign func = mul_func_t'(req_i.funct3);

  // MULH signs both, MULHSU only rs1, MULHU none
  assign sign_a = (func == MF_MULH) || (func == MF_MULHSU);
  assign sign_b = (func == MF_MULH);

  // one extra bit so one signed multiply covers all cases
  assign a_ext        = {sign_a & req_i.src1[XLEN-1], req_i.src1};
  assign b_ext        = {sign_b & req_i.src2[XLEN-1], req_i.src2};
  assign product_full = a_ext * b_ext;

  always_comb begin
    data_in.take_high = (func != MF_MUL);
    data_in.product   = product_full[2*XLEN-1:0];
    data_in.dest_tag  = req_i.dest_tag;
    data_in.rob_idx   = req_i.rob_idx;
  end

  // ==============================
  // pipeline registers
  // ==============================

  // stage valids, cleared on reset
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= req_i.valid;
      for (int i = 1; i < STAGES; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // product and tags move together
  always_ff @(posedge clock) begin
    data_q[0] <= data_in;
    for (int i = 1; i < STAGES; i++) begin
      data_q[i] <= data_q[i-1];
    end
  end

  // low word for MUL, high word otherwise
  always_comb begin
    wb_o.valid      = valid_q[STAGES-1];
    wb_o.value      = data_q[STAGES-1].take_high ? data_q[STAGES-1].product[2*XLEN-1:XLEN]
                                                 : data_q[STAGES-1].product[XLEN-1:0];
    wb_o.dest_prf   = data_q[STAGES-1].dest_tag;
    wb_o.rob_idx    = data_q[STAGES-1].rob_idx;
    wb_o.taken      = 1'b0;
    wb_o.is_jump    = 1'b0;
    wb_o.link_value = '0;
  end

  // only the four M-extension multiplies come here
  assert property (@(posedge clock) disable iff (reset) req_i.valid |-> req_i.funct3 < 3'd4)
    else $error("mul_unit: funct3 %0d is not a multiply", req_i.funct3);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the fu_cluster testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f \
  --top-module tb_fu_cluster -o sim_fu_cluster

out=$(./obj_dir/sim_fu_cluster || true)
echo "$out"

if echo "$out" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1

/* tb_fu_cluster.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fu_params.svh"

module tb_fu_cluster;

  import fu_pkg::*;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 5;
  localparam int STAGES       = `FU_MUL_STAGES;
  // operations issued per unit
  localparam int N_ALU  = 40;
  localparam int N_MUL  = 24;
  localparam int N_LS   = 24;
  localparam int N_BR   = 32;
  localparam int MARGIN = 40;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_ALU + N_MUL + N_LS + N_BR + STAGES + MARGIN;

  localparam word_t SIGN_BIT = word_t'(1) << (XLEN - 1);
  // beq bne blt bge bltu bgeu
  localparam logic [2:0] BR_CODES [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

  // expected multiplier result and the edge it is due
  typedef struct packed {
    logic [31:0] due;
    fu_wb_t      wb;
  } mul_exp_t;

  logic        clock;
  logic        reset;
  fu_req_t     alu_req;
  fu_req_t     mul_req;
  fu_req_t     ls_req;
  fu_req_t     br_req;
  fu_wb_t      wb [WB_SLOTS];
  fu_lsq_t     lsq;
  fu_wb_t      exp_alu;
  fu_wb_t      exp_mul;
  fu_wb_t      exp_br;
  fu_lsq_t     exp_lsq;
  mul_exp_t    mul_q [$];
  logic [31:0] edge_cnt = '0;
  logic        check_en = 1'b0;
  integer      seed;

  fu_cluster dut (
    .clock     (clock),
    .reset     (reset),
    .alu_req_i (alu_req),
    .mul_req_i (mul_req),
    .ls_req_i  (ls_req),
    .br_req_i  (br_req),
    .wb_o      (wb),
    .lsq_o     (lsq)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // ==============================
  // reference model
  // ==============================
  function automatic word_t alu_model(alu_op_t op, word_t a, word_t b);
    logic [`FU_SHAMT_BITS-1:0] sh;
    word_t                     fill;
    sh   = b[`FU_SHAMT_BITS-1:0];
    // ones shifted in from the top for a negative sra
    fill = a[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0;
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      // flipping the sign bit turns signed order into unsigned order
      ALU_SLT:  return word_t'((a ^ SIGN_BIT) < (b ^ SIGN_BIT));
      ALU_SLTU: return word_t'(a < b);
      ALU_SLL:  return a << sh;
      ALU_SRL:  return a >> sh;
      ALU_SRA:  return (a >> sh) | fill;
      default:  return '0;
    endcase
  endfunction

  function automatic word_t mul_model(logic [2:0] f, word_t a, word_t b);
    longint          sa;
    longint          sb;
    longint unsigned ua;
    longint unsigned ub;
    longint          p;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    ua = {32'b0, a};
    ub = {32'b0, b};
    case (f)
      3'd1:    p = sa * sb;
      // signed rs1 times unsigned rs2 still fits in 64 bits
      3'd2:    p = sa * longint'(ub);
      default: p = longint'(ua * ub);
    endcase
    return (f == 3'd0) ? p[31:0] : p[63:32];
  endfunction

  function automatic logic br_model(logic [2:0] f, logic uncond, word_t a, word_t b);
    logic lt_s;
    logic lt_u;
    lt_s = (a ^ SIGN_BIT) < (b ^ SIGN_BIT);
    lt_u = a < b;
    if (uncond) return 1'b1;
    case (f)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return lt_s;
      3'b101:  return !lt_s;
      3'b110:  return lt_u;
      3'b111:  return !lt_u;
      default: return 1'b0;
    endcase
  endfunction

  // valid must agree, payload only matters when valid
  function automatic logic wb_match(fu_wb_t got, fu_wb_t exp);
    if (got.valid != exp.valid) return 1'b0;
    return !exp.valid || (got == exp);
  endfunction

  // expected multiplier output, popped on the edge it is due
  always @(posedge clock) begin
    edge_cnt <= edge_cnt + 1;
    check_en <= 1'b1;
    if (mul_q.size() != 0 && mul_q[0].due == edge_cnt) begin
      exp_mul <= mul_q[0].wb;
      mul_q.delete(0);
    end else begin
      exp_mul <= '0;
    end
  end

  // ==============================
  // checks
  // ==============================
  task automatic report_mismatch(string what);
    $display("Mismatch at %0t: %s", $time, what);
    $display("Result: FAILED");
    $fatal(1, "check failed");
  endtask

  assert property (@(posedge clock) check_en |-> wb_match(wb[WB_ALU], exp_alu))
    else report_mismatch("alu write-back slot differs from model");
  assert property (@(posedge clock) check_en |-> wb_match(wb[WB_MUL], exp_mul))
    else report_mismatch("multiplier write-back slot differs from model");
  assert property (@(posedge clock) check_en |-> wb_match(wb[WB_BR], exp_br))
    else report_mismatch("branch write-back slot differs from model");
  assert property (@(posedge clock) check_en |->
                   lsq.valid == exp_lsq.valid && (!exp_lsq.valid || lsq == exp_lsq))
    else report_mismatch("load/store queue record differs from model");

  // ==============================
  // stimulus
  // ==============================
  function automatic fu_req_t rand_req();
    fu_req_t r;
    r          = '0;
    r.valid    = 1'b1;
    r.src1     = $random(seed);
    r.src2     = $random(seed);
    r.imm      = $random(seed);
    r.pc       = word_t'($random(seed)) & ~word_t'(3);
    r.npc      = r.pc + 32'd4;
    r.dest_tag = prf_tag_t'($random(seed));
    r.rob_idx  = rob_idx_t'($random(seed));
    return r;
  endfunction

  task automatic drive_idle();
    @(posedge clock);
    alu_req <= '0;
    mul_req <= '0;
    ls_req  <= '0;
    br_req  <= '0;
    exp_alu <= '0;
    exp_br  <= '0;
    exp_lsq <= '0;
  endtask

  // every op in turn, result same cycle
  task automatic run_alu();
    fu_req_t r;
    fu_wb_t  e;
    for (int n = 0; n < N_ALU; n++) begin
      r          = rand_req();
      r.alu_op   = alu_op_t'(n % 10);
      e          = '0;
      e.valid    = 1'b1;
      e.value    = alu_model(r.alu_op, r.src1, r.src2);
      e.dest_prf = r.dest_tag;
      e.rob_idx  = r.rob_idx;
      @(posedge clock);
      alu_req <= r;
      exp_alu <= e;
    end
    drive_idle();
  endtask

  // back to back, all four funct3 codes
  task automatic run_mul();
    fu_req_t  r;
    fu_wb_t   e;
    mul_exp_t m;
    for (int n = 0; n < N_MUL; n++) begin
      r          = rand_req();
      r.funct3   = 3'(n % 4);
      e          = '0;
      e.valid    = 1'b1;
      e.value    = mul_model(r.funct3, r.src1, r.src2);
      e.dest_prf = r.dest_tag;
      e.rob_idx  = r.rob_idx;
      @(posedge clock);
      mul_req <= r;
      m.due    = edge_cnt + STAGES;
      m.wb     = e;
      mul_q.push_back(m);
    end
    drive_idle();
    // drain the pipe
    while (mul_q.size() != 0) @(posedge clock);
    repeat (2) @(posedge clock);
  endtask

  // load, store, neither in rotation
  task automatic run_ls();
    fu_req_t                 r;
    fu_lsq_t                 e;
    logic [`FU_IMM_BITS-1:0] imm_raw;
    for (int n = 0; n < N_LS; n++) begin
      r          = rand_req();
      // upper imm bits stay random, only the raw field counts
      imm_raw    = r.imm[`FU_IMM_BITS-1:0];
      r.funct3   = 3'($random(seed));
      r.is_load  = (n % 3 == 0);
      r.is_store = (n % 3 == 1);
      e          = '0;
      e.valid    = r.is_load || r.is_store;
      e.is_store = r.is_store;
      e.rob_idx  = r.rob_idx;
      e.addr     = r.src1 + word_t'($signed(imm_raw));
      if (r.is_load) begin
        e.dest_prf = r.dest_tag;
        e.funct3   = r.funct3;
      end
      if (r.is_store) e.store_data = r.src2;
      @(posedge clock);
      ls_req  <= r;
      exp_lsq <= e;
    end
    drive_idle();
  endtask

  // six conditions on five operand pairs, then jumps
  task automatic run_br();
    fu_req_t r;
    fu_wb_t  e;
    for (int n = 0; n < N_BR; n++) begin
      r        = rand_req();
      r.uncond = (n >= 30);
      r.funct3 = BR_CODES[(n / 5) % 6];
      case (n % 5)
        0: r.src2 = r.src1;
        1: begin
          r.src1 = 32'd5;
          r.src2 = 32'd9;
        end
        2: begin
          r.src1 = 32'd9;
          r.src2 = 32'd5;
        end
        // signed less but unsigned greater
        3: begin
          r.src1 = 32'hffff_fff0;
          r.src2 = 32'd16;
        end
        default: begin
          r.src1 = 32'd16;
          r.src2 = 32'hffff_fff0;
        end
      endcase
      e            = '0;
      e.valid      = 1'b1;
      e.value      = r.pc + r.imm;
      e.dest_prf   = r.dest_tag;
      e.rob_idx    = r.rob_idx;
      e.taken      = br_model(r.funct3, r.uncond, r.src1, r.src2);
      e.is_jump    = r.uncond;
      e.link_value = r.npc;
      @(posedge clock);
      br_req <= r;
      exp_br <= e;
    end
    drive_idle();
  endtask

  initial begin
    seed     = 32'h1b56_9a39;
    reset    = 1'b1;
    alu_req  = '0;
    mul_req  = '0;
    ls_req   = '0;
    br_req   = '0;
    exp_alu  = '0;
    exp_br   = '0;
    exp_lsq  = '0;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
    run_alu();
    run_mul();
    run_ls();
    run_br();
    repeat (2) @(posedge clock);
    $display("Result: PASSED");
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire
